//--- design/lsu_sq_pkg.sv
// Store queue package with the store op, payload and entry state types
`default_nettype none

package lsu_sq_pkg;

    // Size of the store being written to memory
    typedef enum logic [1:0] {
        STORE_BYTE = 2'b00,
        STORE_HALF = 2'b01,
        STORE_WORD = 2'b10
    } sq_op_t;

    // Store address and data as seen by the data cache
    typedef logic [31:0] sq_addr_t;
    typedef logic [31:0] sq_data_t;

    // Reorder buffer index carried with every store
    typedef logic [4:0] rob_tag_t;

    // Life of one store queue entry
    // WAITING holds a speculative store, RETIRABLE a committed one that has not gone out yet,
    // and LAUNCHED one that is in flight toward the cache and awaits its update
    typedef enum logic [1:0] {
        SQ_EMPTY      = 2'b00,
        SQ_WAITING    = 2'b01,
        SQ_RETIRABLE  = 2'b10,
        SQ_LAUNCHED   = 2'b11
    } sq_state_t;

endpackage : lsu_sq_pkg

`default_nettype wire

//--- design/sq_alloc.sv
// Store queue allocator that picks a free entry and returns freed entries as credits
`default_nettype none
`timescale 1ns/10ps

module sq_alloc #(
    parameter int SQ_DEPTH = 8
) (
    input  wire logic                              clk,
    input  wire logic                              i_reset,

    input  wire logic                              i_alloc_en,
    input  wire logic [SQ_DEPTH-1:0]               i_entry_empty,
    input  wire logic [SQ_DEPTH-1:0]               i_entry_freed,

    output logic      [SQ_DEPTH-1:0]               o_alloc_select,
    output logic      [$clog2(SQ_DEPTH+1)-1:0]     o_credit_return
);

    localparam int CREDIT_W = $clog2(SQ_DEPTH + 1);

    logic [SQ_DEPTH-1:0] empty_pick;
    logic [CREDIT_W-1:0] freed_count;

    // Isolate the lowest set bit of the empty vector
    assign empty_pick = i_entry_empty & (~i_entry_empty + 1'b1);

    assign o_alloc_select = empty_pick & {SQ_DEPTH{i_alloc_en}};

    // Several entries can free in one cycle when a flush and an update coincide
    always_comb begin
        freed_count = '0;
        for (int i = 0; i < SQ_DEPTH; i++) begin
            freed_count = freed_count + CREDIT_W'(i_entry_freed[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_credit_return <= '0;
        end else begin
            o_credit_return <= freed_count;
        end
    end

    // The issuer only allocates while it holds a credit, so an empty entry must exist
    a_alloc_has_room: assert property (
        @(posedge clk) disable iff (i_reset)
        i_alloc_en |-> (i_entry_empty != '0)
    ) else $error("Store allocated with no empty entry");

endmodule : sq_alloc

`default_nettype wire

//--- design/sq_entry.sv
// Store queue entry holding one store from allocation until the cache accepts it
`default_nettype none
`timescale 1ns/10ps

module sq_entry
    import lsu_sq_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     i_reset,
    input  wire logic     i_flush,

    input  wire logic     i_alloc_en,
    input  wire sq_op_t   i_alloc_op,
    input  wire rob_tag_t i_alloc_tag,
    input  wire sq_addr_t i_alloc_addr,
    input  wire sq_data_t i_alloc_data,

    input  wire logic     i_launch_en,
    input  wire logic     i_update_en,
    input  wire logic     i_update_retry,

    input  wire logic     i_rob_retire_en,
    input  wire rob_tag_t i_rob_retire_tag,

    output logic          o_empty,
    output logic          o_retirable,
    output logic          o_freed,
    output logic          o_rob_match,
    output sq_op_t        o_op,
    output sq_addr_t      o_addr,
    output rob_tag_t      o_tag,
    output sq_data_t      o_data
);

    sq_state_t state;
    sq_state_t state_next;

    // Only a speculative store listens for its retirement
    assign o_rob_match = i_rob_retire_en && (state == SQ_WAITING) && (o_tag == i_rob_retire_tag);

    // A store retired in the flush cycle is older than the flush and survives it
    assign o_freed = ((state == SQ_LAUNCHED) && i_update_en && !i_update_retry) ||
                     ((state == SQ_WAITING) && i_flush && !o_rob_match);

    assign o_empty     = (state == SQ_EMPTY);
    assign o_retirable = (state == SQ_RETIRABLE);

    always_comb begin
        state_next = state;
        case (state)
            SQ_EMPTY: begin
                if (i_alloc_en) begin
                    state_next = SQ_WAITING;
                end
            end
            SQ_WAITING: begin
                if (o_rob_match) begin
                    state_next = SQ_RETIRABLE;
                end else if (i_flush) begin
                    state_next = SQ_EMPTY;
                end
            end
            SQ_RETIRABLE: begin
                if (i_launch_en) begin
                    state_next = SQ_LAUNCHED;
                end
            end
            SQ_LAUNCHED: begin
                // A retry sends the store back to be launched again later
                if (i_update_en) begin
                    state_next = i_update_retry ? SQ_RETIRABLE : SQ_EMPTY;
                end
            end
            default: state_next = SQ_EMPTY;
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state <= SQ_EMPTY;
        end else begin
            state <= state_next;
        end
    end

    // Payload is only meaningful once the entry has left the empty state
    always_ff @(posedge clk) begin
        if (i_alloc_en) begin
            o_op   <= i_alloc_op;
            o_tag  <= i_alloc_tag;
            o_addr <= i_alloc_addr;
            o_data <= i_alloc_data;
        end
    end

    // The launcher and the cache update path must agree with this entry's state
    a_launch_when_retirable: assert property (
        @(posedge clk) disable iff (i_reset)
        i_launch_en |-> (state == SQ_RETIRABLE)
    ) else $error("Launch selected an entry that is not retirable");

    a_update_when_launched: assert property (
        @(posedge clk) disable iff (i_reset)
        i_update_en |-> (state == SQ_LAUNCHED)
    ) else $error("Update addressed an entry that was not launched");

endmodule : sq_entry

`default_nettype wire

//--- design/sq_launch.sv
// Store queue launcher that picks the oldest-slot retirable store and registers it toward the cache
`default_nettype none
`timescale 1ns/10ps

module sq_launch
    import lsu_sq_pkg::*;
#(
    parameter int SQ_DEPTH = 8
) (
    input  wire logic                 clk,
    input  wire logic                 i_reset,
    input  wire logic                 i_flush,
    input  wire logic                 i_launch_stall,

    input  wire logic [SQ_DEPTH-1:0]  i_entry_retirable,
    input  wire sq_op_t               i_entry_op   [SQ_DEPTH],
    input  wire sq_addr_t             i_entry_addr [SQ_DEPTH],
    input  wire rob_tag_t             i_entry_tag  [SQ_DEPTH],
    input  wire sq_data_t             i_entry_data [SQ_DEPTH],

    output logic      [SQ_DEPTH-1:0]  o_entry_launch,

    output logic                      o_launch_en,
    output logic      [SQ_DEPTH-1:0]  o_launch_select,
    output sq_op_t                    o_launch_op,
    output sq_addr_t                  o_launch_addr,
    output rob_tag_t                  o_launch_tag,
    output sq_data_t                  o_launch_data
);

    localparam int IDX_W = (SQ_DEPTH == 1) ? 1 : $clog2(SQ_DEPTH);

    logic [SQ_DEPTH-1:0] retire_pick;
    logic [IDX_W-1:0]    pick_idx;
    logic                hold_n;

    // Lowest index retirable entry wins
    assign retire_pick = i_entry_retirable & (~i_entry_retirable + 1'b1);

    assign hold_n = !i_launch_stall;

    // A flush blocks the launch so the entries see a quiet cycle while they drop speculative stores
    assign o_entry_launch = retire_pick & {SQ_DEPTH{hold_n && !i_flush}};

    always_comb begin
        pick_idx = '0;
        for (int i = 0; i < SQ_DEPTH; i++) begin
            if (retire_pick[i]) begin
                pick_idx = pick_idx | IDX_W'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_launch_en     <= 1'b0;
            o_launch_select <= '0;
        end else if (hold_n) begin
            o_launch_en     <= (o_entry_launch != '0);
            o_launch_select <= o_entry_launch;
        end
    end

    // Fields follow the same hold as the valid bit so a stalled launch stays intact
    always_ff @(posedge clk) begin
        if (hold_n) begin
            o_launch_op   <= i_entry_op[pick_idx];
            o_launch_addr <= i_entry_addr[pick_idx];
            o_launch_tag  <= i_entry_tag[pick_idx];
            o_launch_data <= i_entry_data[pick_idx];
        end
    end

endmodule : sq_launch

`default_nettype wire

//--- design/lsu_sq.sv
// Store queue top level tying the allocator, the entry array and the launcher together
`default_nettype none
`timescale 1ns/10ps

module lsu_sq
    import lsu_sq_pkg::*;
#(
    parameter int SQ_DEPTH = 8
) (
    input  wire logic                            clk,
    input  wire logic                            i_reset,
    input  wire logic                            i_flush,

    // Issued stores and the credits that pay for them
    input  wire logic                            i_alloc_en,
    input  wire sq_op_t                          i_alloc_op,
    input  wire rob_tag_t                        i_alloc_tag,
    input  wire sq_addr_t                        i_alloc_addr,
    input  wire sq_data_t                        i_alloc_data,
    output logic      [$clog2(SQ_DEPTH+1)-1:0]   o_credit_return,

    input  wire logic                            i_rob_retire_en,
    input  wire rob_tag_t                        i_rob_retire_tag,
    output logic                                 o_rob_retire_ack,

    // Stores going out to the data cache
    input  wire logic                            i_launch_stall,
    output logic                                 o_launch_en,
    output logic      [SQ_DEPTH-1:0]             o_launch_select,
    output sq_op_t                               o_launch_op,
    output sq_addr_t                             o_launch_addr,
    output rob_tag_t                             o_launch_tag,
    output sq_data_t                             o_launch_data,

    input  wire logic                            i_update_en,
    input  wire logic [SQ_DEPTH-1:0]             i_update_select,
    input  wire logic                            i_update_retry
);

    logic [SQ_DEPTH-1:0] entry_empty;
    logic [SQ_DEPTH-1:0] entry_retirable;
    logic [SQ_DEPTH-1:0] entry_freed;
    logic [SQ_DEPTH-1:0] entry_match;
    logic [SQ_DEPTH-1:0] alloc_select;
    logic [SQ_DEPTH-1:0] launch_select;
    logic [SQ_DEPTH-1:0] update_select;

    sq_op_t   entry_op   [SQ_DEPTH];
    sq_addr_t entry_addr [SQ_DEPTH];
    rob_tag_t entry_tag  [SQ_DEPTH];
    sq_data_t entry_data [SQ_DEPTH];

    assign update_select = i_update_select & {SQ_DEPTH{i_update_en}};

    sq_alloc #(
        .SQ_DEPTH        (SQ_DEPTH)
    ) i_sq_alloc (
        .clk             (clk),
        .i_reset         (i_reset),
        .i_alloc_en      (i_alloc_en),
        .i_entry_empty   (entry_empty),
        .i_entry_freed   (entry_freed),
        .o_alloc_select  (alloc_select),
        .o_credit_return (o_credit_return)
    );

    for (genvar i = 0; i < SQ_DEPTH; i++) begin : g_entry
        sq_entry i_sq_entry (
            .clk              (clk),
            .i_reset          (i_reset),
            .i_flush          (i_flush),
            .i_alloc_en       (alloc_select[i]),
            .i_alloc_op       (i_alloc_op),
            .i_alloc_tag      (i_alloc_tag),
            .i_alloc_addr     (i_alloc_addr),
            .i_alloc_data     (i_alloc_data),
            .i_launch_en      (launch_select[i]),
            .i_update_en      (update_select[i]),
            .i_update_retry   (i_update_retry),
            .i_rob_retire_en  (i_rob_retire_en),
            .i_rob_retire_tag (i_rob_retire_tag),
            .o_empty          (entry_empty[i]),
            .o_retirable      (entry_retirable[i]),
            .o_freed          (entry_freed[i]),
            .o_rob_match      (entry_match[i]),
            .o_op             (entry_op[i]),
            .o_addr           (entry_addr[i]),
            .o_tag            (entry_tag[i]),
            .o_data           (entry_data[i])
        );
    end

    sq_launch #(
        .SQ_DEPTH          (SQ_DEPTH)
    ) i_sq_launch (
        .clk               (clk),
        .i_reset           (i_reset),
        .i_flush           (i_flush),
        .i_launch_stall    (i_launch_stall),
        .i_entry_retirable (entry_retirable),
        .i_entry_op        (entry_op),
        .i_entry_addr      (entry_addr),
        .i_entry_tag       (entry_tag),
        .i_entry_data      (entry_data),
        .o_entry_launch    (launch_select),
        .o_launch_en       (o_launch_en),
        .o_launch_select   (o_launch_select),
        .o_launch_op       (o_launch_op),
        .o_launch_addr     (o_launch_addr),
        .o_launch_tag      (o_launch_tag),
        .o_launch_data     (o_launch_data)
    );

    // The reorder buffer learns a cycle later whether a waiting store took its tag
    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_rob_retire_ack <= 1'b0;
        end else begin
            o_rob_retire_ack <= (entry_match != '0);
        end
    end

    // Tags of in-flight stores are unique, so two entries never claim one retirement
    a_single_tag_match: assert property (
        @(posedge clk) disable iff (i_reset)
        $onehot0(entry_match)
    ) else $error("More than one store entry matched the retiring tag");

endmodule : lsu_sq

`default_nettype wire

//--- tests/lsu_sq_tb.sv
// Store queue testbench driving allocation, retirement, launch, update and flush sequences
`default_nettype none
`timescale 1ns/10ps

module lsu_sq_tb
    import lsu_sq_pkg::*;
();

    localparam int SQ_DEPTH         = 8;
    localparam int CREDIT_W         = $clog2(SQ_DEPTH + 1);
    localparam int CLK_PERIOD       = 8;
    localparam int RESET_CYCLES     = 10;
    localparam int TOTAL_STORES     = 17;
    localparam int CYCLES_PER_STORE = 40;

    logic                clk;
    logic                i_reset;
    logic                i_flush;
    logic                i_alloc_en;
    sq_op_t              i_alloc_op;
    rob_tag_t            i_alloc_tag;
    sq_addr_t            i_alloc_addr;
    sq_data_t            i_alloc_data;
    logic [CREDIT_W-1:0] o_credit_return;
    logic                i_rob_retire_en;
    rob_tag_t            i_rob_retire_tag;
    logic                o_rob_retire_ack;
    logic                i_launch_stall;
    logic                o_launch_en;
    logic [SQ_DEPTH-1:0] o_launch_select;
    sq_op_t              o_launch_op;
    sq_addr_t            o_launch_addr;
    rob_tag_t            o_launch_tag;
    sq_data_t            o_launch_data;
    logic                i_update_en;
    logic [SQ_DEPTH-1:0] i_update_select;
    logic                i_update_retry;

    // Reference view of every entry, kept in step with the queue rules
    sq_state_t model_state [SQ_DEPTH];
    sq_op_t    model_op    [SQ_DEPTH];
    sq_addr_t  model_addr  [SQ_DEPTH];
    rob_tag_t  model_tag   [SQ_DEPTH];
    sq_data_t  model_data  [SQ_DEPTH];

    int          allocs_made;
    int          credits_returned;

    lsu_sq #(
        .SQ_DEPTH (SQ_DEPTH)
    ) i_lsu_sq (
        .clk              (clk),
        .i_reset          (i_reset),
        .i_flush          (i_flush),
        .i_alloc_en       (i_alloc_en),
        .i_alloc_op       (i_alloc_op),
        .i_alloc_tag      (i_alloc_tag),
        .i_alloc_addr     (i_alloc_addr),
        .i_alloc_data     (i_alloc_data),
        .o_credit_return  (o_credit_return),
        .i_rob_retire_en  (i_rob_retire_en),
        .i_rob_retire_tag (i_rob_retire_tag),
        .o_rob_retire_ack (o_rob_retire_ack),
        .i_launch_stall   (i_launch_stall),
        .o_launch_en      (o_launch_en),
        .o_launch_select  (o_launch_select),
        .o_launch_op      (o_launch_op),
        .o_launch_addr    (o_launch_addr),
        .o_launch_tag     (o_launch_tag),
        .o_launch_data    (o_launch_data),
        .i_update_en      (i_update_en),
        .i_update_select  (i_update_select),
        .i_update_retry   (i_update_retry)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Returned credits are registered, so they are picked up at the edge after they appear
    always @(posedge clk) begin
        if (i_reset) begin
            credits_returned <= 0;
        end else begin
            credits_returned <= credits_returned + int'(o_credit_return);
        end
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string msg);
        if (actual !== expected) begin
            fail_run($sformatf("Mismatch at %0t ns: %s, got 0x%0h, expected 0x%0h",
                               $time, msg, actual, expected));
        end
    endtask

    function automatic int credits_held();
        return SQ_DEPTH - allocs_made + credits_returned;
    endfunction

    function automatic int lowest_in_state(input sq_state_t state);
        int found;
        found = -1;
        for (int i = SQ_DEPTH - 1; i >= 0; i--) begin
            if (model_state[i] == state) begin
                found = i;
            end
        end
        return found;
    endfunction

    function automatic int count_in_state(input sq_state_t state);
        int count;
        count = 0;
        for (int i = 0; i < SQ_DEPTH; i++) begin
            if (model_state[i] == state) begin
                count++;
            end
        end
        return count;
    endfunction

    function automatic int find_waiting_tag(input rob_tag_t tag);
        int found;
        found = -1;
        for (int i = 0; i < SQ_DEPTH; i++) begin
            if (model_state[i] == SQ_WAITING && model_tag[i] == tag) begin
                found = i;
            end
        end
        return found;
    endfunction

    task automatic alloc_store(input sq_op_t op, input rob_tag_t tag, input sq_addr_t addr,
                               input sq_data_t data);
        int idx;
        @(negedge clk);
        idx = lowest_in_state(SQ_EMPTY);
        if (credits_held() <= 0 || idx < 0) begin
            fail_run("Test tried to allocate a store without holding a credit");
        end
        @(posedge clk);
        i_alloc_en   <= 1'b1;
        i_alloc_op   <= op;
        i_alloc_tag  <= tag;
        i_alloc_addr <= addr;
        i_alloc_data <= data;
        @(posedge clk);
        i_alloc_en <= 1'b0;
        allocs_made++;
        model_state[idx] = SQ_WAITING;
        model_op[idx]    = op;
        model_tag[idx]   = tag;
        model_addr[idx]  = addr;
        model_data[idx]  = data;
    endtask

    // The acknowledge must show up in the cycle after the retirement and in no other
    task automatic retire_tag(input rob_tag_t tag);
        int idx;
        idx = find_waiting_tag(tag);
        @(posedge clk);
        i_rob_retire_en  <= 1'b1;
        i_rob_retire_tag <= tag;
        @(negedge clk);
        check_value(32'(o_rob_retire_ack), 32'd0, "retire ack before its cycle");
        @(posedge clk);
        i_rob_retire_en <= 1'b0;
        @(negedge clk);
        check_value(32'(o_rob_retire_ack), 32'(idx >= 0), "retire ack one cycle after retire");
        if (idx >= 0) begin
            model_state[idx] = SQ_RETIRABLE;
        end
        @(negedge clk);
        check_value(32'(o_rob_retire_ack), 32'd0, "retire ack held too long");
    endtask

    // Skips one cycle so an output held under the old stall value is not taken as new
    task automatic drive_stall(input logic value);
        @(posedge clk);
        i_launch_stall <= value;
        @(negedge clk);
    endtask

    task automatic expect_launch();
        int idx;
        int waited;
        idx = lowest_in_state(SQ_RETIRABLE);
        if (idx < 0) begin
            fail_run("Test expected a launch while no store was retirable");
        end
        waited = 0;
        @(negedge clk);
        while (!o_launch_en && waited < 8) begin
            @(negedge clk);
            waited++;
        end
        if (!o_launch_en) begin
            fail_run("A retirable store was never launched toward the cache");
        end
        check_value(32'(o_launch_select), 32'(SQ_DEPTH'(1) << idx), "launch select");
        check_value(32'(o_launch_op), 32'(model_op[idx]), "launch op");
        check_value(o_launch_addr, model_addr[idx], "launch address");
        check_value(32'(o_launch_tag), 32'(model_tag[idx]), "launch tag");
        check_value(o_launch_data, model_data[idx], "launch data");
        model_state[idx] = SQ_LAUNCHED;
    endtask

    task automatic update_entry(input int idx, input logic retry);
        if (model_state[idx] != SQ_LAUNCHED) begin
            fail_run("Test tried to update a store that was not launched");
        end
        @(posedge clk);
        i_update_en     <= 1'b1;
        i_update_select <= SQ_DEPTH'(1) << idx;
        i_update_retry  <= retry;
        @(posedge clk);
        i_update_en     <= 1'b0;
        i_update_select <= '0;
        i_update_retry  <= 1'b0;
        model_state[idx] = retry ? SQ_RETIRABLE : SQ_EMPTY;
        @(negedge clk);
        check_value(32'(o_credit_return), retry ? 32'd0 : 32'd1, "credits returned by update");
    endtask

    task automatic flush_queue();
        int expected;
        expected = count_in_state(SQ_WAITING);
        @(posedge clk);
        i_flush <= 1'b1;
        @(posedge clk);
        i_flush <= 1'b0;
        for (int i = 0; i < SQ_DEPTH; i++) begin
            if (model_state[i] == SQ_WAITING) begin
                model_state[i] = SQ_EMPTY;
            end
        end
        @(negedge clk);
        check_value(32'(o_credit_return), 32'(expected), "credits returned by flush");
    endtask

    task automatic settle_credits(input string msg);
        repeat (2) @(negedge clk);
        check_value(32'(credits_held()), 32'(count_in_state(SQ_EMPTY)), msg);
    endtask

    task automatic check_idle_after_reset();
        @(negedge clk);
        check_value(32'(o_launch_en), 32'd0, "launch valid after reset");
        check_value(32'(o_rob_retire_ack), 32'd0, "retire ack after reset");
        check_value(32'(o_credit_return), 32'd0, "credit return after reset");
        drive_stall(1'b0);
        alloc_store(STORE_WORD, 5'd1, 32'h1000_0000, 32'hdead_beef);
        repeat (6) begin
            @(negedge clk);
            check_value(32'(o_launch_en), 32'd0, "launch of an unretired store");
        end
        flush_queue();
        drive_stall(1'b1);
        settle_credits("credits after the idle check");
    endtask

    task automatic run_single_store();
        alloc_store(STORE_BYTE, 5'd7, 32'h0000_1004, 32'h0000_00a5);
        // No waiting store carries tag 9, so this retirement gets no acknowledge
        retire_tag(5'd9);
        retire_tag(5'd7);
        drive_stall(1'b0);
        expect_launch();
        check_value(32'(o_launch_select), 32'h1, "single store launched from entry 0");
        drive_stall(1'b1);
        update_entry(0, 1'b0);
        settle_credits("credits after a single store");
    endtask

    task automatic fill_and_drain();
        rob_tag_t            order [SQ_DEPTH];
        rob_tag_t            swap;
        int                  j;
        logic [SQ_DEPTH-1:0] held_select;
        sq_op_t              held_op;
        sq_addr_t            held_addr;
        rob_tag_t            held_tag;
        sq_data_t            held_data;
        for (int i = 0; i < SQ_DEPTH; i++) begin
            alloc_store(sq_op_t'($urandom_range(2)), rob_tag_t'(8 + i), $urandom, $urandom);
            order[i] = rob_tag_t'(8 + i);
        end
        check_value(32'(credits_held()), 32'd0, "credits left with a full queue");
        for (int i = SQ_DEPTH - 1; i > 0; i--) begin
            j        = $urandom_range(i);
            swap     = order[i];
            order[i] = order[j];
            order[j] = swap;
        end
        for (int i = 0; i < SQ_DEPTH; i++) begin
            retire_tag(order[i]);
        end
        drive_stall(1'b0);
        expect_launch();
        // The edge that raises the stall still launches the second store
        drive_stall(1'b1);
        expect_launch();
        held_select = o_launch_select;
        held_op     = o_launch_op;
        held_addr   = o_launch_addr;
        held_tag    = o_launch_tag;
        held_data   = o_launch_data;
        repeat (4) begin
            @(negedge clk);
            check_value(32'(o_launch_en), 32'd1, "launch valid under stall");
            check_value(32'(o_launch_select), 32'(held_select), "launch select under stall");
            check_value(32'(o_launch_op), 32'(held_op), "launch op under stall");
            check_value(o_launch_addr, held_addr, "launch address under stall");
            check_value(32'(o_launch_tag), 32'(held_tag), "launch tag under stall");
            check_value(o_launch_data, held_data, "launch data under stall");
        end
        drive_stall(1'b0);
        repeat (SQ_DEPTH - 2) expect_launch();
        drive_stall(1'b1);
        for (int i = 0; i < SQ_DEPTH; i++) begin
            update_entry(i, 1'b0);
        end
        settle_credits("credits after draining a full queue");
    endtask

    task automatic replay_on_retry();
        int idx;
        alloc_store(STORE_HALF, 5'd3, 32'h0000_2468, 32'h1357_9bdf);
        retire_tag(5'd3);
        drive_stall(1'b0);
        expect_launch();
        drive_stall(1'b1);
        idx = lowest_in_state(SQ_LAUNCHED);
        update_entry(idx, 1'b1);
        repeat (3) begin
            @(negedge clk);
            check_value(32'(o_credit_return), 32'd0, "credit returned after a retry");
        end
        drive_stall(1'b0);
        expect_launch();
        drive_stall(1'b1);
        update_entry(idx, 1'b0);
        settle_credits("credits after a retried store");
    endtask

    task automatic flush_with_mix();
        for (int i = 0; i < 6; i++) begin
            alloc_store(sq_op_t'($urandom_range(2)), rob_tag_t'(16 + i), $urandom, $urandom);
        end
        retire_tag(5'd17);
        retire_tag(5'd19);
        retire_tag(5'd20);
        flush_queue();
        // A flushed store no longer answers its tag
        retire_tag(5'd16);
        drive_stall(1'b0);
        repeat (3) expect_launch();
        drive_stall(1'b1);
        for (int i = 0; i < SQ_DEPTH; i++) begin
            if (model_state[i] == SQ_LAUNCHED) begin
                update_entry(i, 1'b0);
            end
        end
        settle_credits("credits after a flush");
        check_value(32'(credits_held()), 32'(SQ_DEPTH), "credits back at full depth");
    endtask

    initial begin
        repeat (RESET_CYCLES + CYCLES_PER_STORE * TOTAL_STORES) @(posedge clk);
        fail_run("Watchdog timeout: the tests did not finish in the expected number of cycles");
    end

    initial begin
        void'($urandom(32'hec31_236b));
        clk              = 1'b0;
        i_reset          = 1'b1;
        i_flush          = 1'b0;
        i_alloc_en       = 1'b0;
        i_alloc_op       = STORE_BYTE;
        i_alloc_tag      = '0;
        i_alloc_addr     = '0;
        i_alloc_data     = '0;
        i_rob_retire_en  = 1'b0;
        i_rob_retire_tag = '0;
        i_launch_stall   = 1'b1;
        i_update_en      = 1'b0;
        i_update_select  = '0;
        i_update_retry   = 1'b0;
        allocs_made      = 0;
        for (int i = 0; i < SQ_DEPTH; i++) begin
            model_state[i] = SQ_EMPTY;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        i_reset <= 1'b0;
        check_idle_after_reset();
        run_single_store();
        fill_and_drain();
        replay_on_retry();
        flush_with_mix();
        $display("Simulation PASSED");
        $finish;
    end

endmodule : lsu_sq_tb

`default_nettype wire

//--- list.f
design/lsu_sq_pkg.sv
design/sq_alloc.sv
design/sq_entry.sv
design/sq_launch.sv
design/lsu_sq.sv
tests/lsu_sq_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the store queue testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module lsu_sq_tb -o lsu_sq_sim -f list.f > build.log 2>&1 \
    && ./obj_dir/lsu_sq_sim > sim.log 2>&1 \
    || echo "Build or simulation exited with an error, see build.log and sim.log"

touch sim.log
grep -q "Simulation PASSED" sim.log \
    && echo "Store queue simulation passed" \
    || { echo "Store queue simulation failed, see sim.log"; exit 1; }
